//--- filelist.f
+incdir+hw
hw/tr_pkg.sv
hw/tr_pipe_stage.sv
hw/tr_alu.sv
hw/tr_replicator.sv
hw/tr_comparator.sv
hw/tr_ctrl.sv
hw/tr_top.sv
tb/tb_tr_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_tr_top -Mdir obj_dir
	-./obj_dir/Vtb_tr_top | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_tr_top.sv
module tb_tr_top;

    localparam logic [31:0] SEED    = 32'd45;
    // Cycles any single wait may take
    localparam int unsigned TIMEOUT = 200;

    // Expected output of one accepted element
    typedef struct packed {
        logic [tr_pkg::DATA_W-1:0] result;
        logic                      fault;
    } exp_t;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           enable_req_i;
    tr_pkg::tr_req_t                op_i;
    logic                           valid_i;
    logic                           ready_o;
    logic [tr_pkg::DATA_W-1:0]      result_o;
    logic                           faulty_o;
    logic                           valid_o;
    logic                           ready_i;
    logic [tr_pkg::FAULT_CNT_W-1:0] fault_count_o;

    // Scoreboard, oldest element first
    exp_t                           exp_q[$];
    logic [31:0]                    stim_state;
    logic [31:0]                    rdy_state;
    logic                           bp_en;
    string                          cur_name;
    logic [tr_pkg::FAULT_CNT_W-1:0] fault_cnt_exp;

    tr_top u_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .enable_req_i  (enable_req_i),
        .op_i          (op_i),
        .valid_i       (valid_i),
        .ready_o       (ready_o),
        .result_o      (result_o),
        .faulty_o      (faulty_o),
        .valid_o       (valid_o),
        .ready_i       (ready_i),
        .fault_count_o (fault_count_o)
    );

    always begin : clk_gen
        #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Reference ALU, product keeps its low half
    function automatic logic [tr_pkg::DATA_W-1:0] model_alu(
        input tr_pkg::alu_op_e           op,
        input logic [tr_pkg::DATA_W-1:0] a,
        input logic [tr_pkg::DATA_W-1:0] b
    );
        logic [2*tr_pkg::DATA_W-1:0] wide;
        wide = {{tr_pkg::DATA_W{1'b0}}, a} * {{tr_pkg::DATA_W{1'b0}}, b};
        case (op)
            tr_pkg::ALU_ADD: return a + b;
            tr_pkg::ALU_SUB: return a - b;
            tr_pkg::ALU_XOR: return a ^ b;
            default:         return wide[tr_pkg::DATA_W-1:0];
        endcase
    endfunction

    task automatic next_stim(output logic [31:0] r);
        stim_state = xorshift(stim_state);
        r = stim_state;
    endtask

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input string name, input logic [tr_pkg::DATA_W-1:0] exp,
                                input logic [tr_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s result expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s flag expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_count(input string name,
                               input logic [tr_pkg::FAULT_CNT_W-1:0] exp,
                               input logic [tr_pkg::FAULT_CNT_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s fault count expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers and monitor
    ////////////////////////////////////////////////////////////////////////////

    // Random ready pattern when back-pressure is on, about three in four high
    always begin : ready_drive
        @(posedge clk_i);
        #1;
        rdy_state = xorshift(rdy_state);
        ready_i   = bp_en ? (rdy_state[1:0] != 2'b00) : 1'b1;
    end

    // Sampled at the falling edge, transfer lands on the next rising edge
    always @(negedge clk_i) begin : monitor
        exp_t e;
        if (rst_ni && valid_o && ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer in %s with no element pending", cur_name);
                fail_run();
            end else begin
                e = exp_q.pop_front();
                check_result(cur_name, e.result, result_o);
                check_fault(cur_name, e.fault, faulty_o);
                // Counter saturates at all ones
                if (e.fault && fault_cnt_exp != '1) begin
                    fault_cnt_exp = fault_cnt_exp + 1'b1;
                end
            end
        end
    end

    // Called just after a rising edge, returns just after a rising edge
    task automatic send_op(input string name, input tr_pkg::tr_req_t op);
        int unsigned waited;
        exp_t        e;
        valid_i = 1'b1;
        op_i    = op;
        waited  = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout in %s, operation never accepted", name);
                fail_run();
            end
            @(negedge clk_i);
        end
        // Intake only opens with no mode change pending
        e.result = model_alu(op.op, op.a, op.b);
        e.fault  = op.tag.inject & enable_req_i;
        exp_q.push_back(e);
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int unsigned waited;
        waited = 0;
        @(negedge clk_i);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout in %s, %0d results never came out", name, exp_q.size());
                fail_run();
            end
            @(negedge clk_i);
        end
        // Count moves on the edge of the last output transfer
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    // inj_mode 0 none, 1 all, 2 about one in four
    task automatic run_phase(input string name, input int unsigned n, input logic en,
                             input int unsigned inj_mode, input logic bp, input logic toggle);
        int unsigned     i;
        logic [31:0]     r0;
        logic [31:0]     r1;
        logic [31:0]     r2;
        tr_pkg::tr_req_t op;
        cur_name     = name;
        bp_en        = bp;
        enable_req_i = en;
        for (i = 0; i < n; i++) begin
            next_stim(r0);
            next_stim(r1);
            next_stim(r2);
            if (toggle && r0[2:0] == 3'd0) begin
                enable_req_i = ~enable_req_i;
            end
            // Occasional idle cycle
            if ((bp || toggle) && r0[5:3] == 3'd0) begin
                @(posedge clk_i);
                #1;
            end
            op            = '0;
            op.op         = tr_pkg::alu_op_e'(r1[1:0]);
            op.a          = r1[31:16];
            op.b          = r2[31:16];
            op.tag.inject = (inj_mode == 1) || (inj_mode == 2 && r2[1:0] == 2'b00);
            send_op(name, op);
        end
        wait_drain(name);
        check_count(name, fault_cnt_exp, fault_count_o);
        @(posedge clk_i);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        enable_req_i  = 1'b0;
        op_i          = '0;
        valid_i       = 1'b0;
        ready_i       = 1'b1;
        bp_en         = 1'b0;
        stim_state    = SEED;
        rdy_state     = SEED ^ 32'h5bd1_e995;
        fault_cnt_exp = '0;
        cur_name      = "reset";
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Idle outputs straight after reset
        @(negedge clk_i);
        check_fault("reset valid", 1'b0, valid_o);
        check_fault("reset faulty", 1'b0, faulty_o);
        check_count("reset", '0, fault_count_o);
        @(posedge clk_i);
        #1;

        run_phase("basic", 200, 1'b1, 0, 1'b0, 1'b0);
        run_phase("inject", 40, 1'b1, 1, 1'b0, 1'b0);
        run_phase("backpressure", 200, 1'b1, 2, 1'b1, 1'b0);
        // Inject on every element, single copies must stay clean
        run_phase("disabled", 150, 1'b0, 1, 1'b1, 1'b0);
        run_phase("toggle", 300, 1'b1, 2, 1'b1, 1'b1);
        // Enough faults to pin the counter at its maximum
        run_phase("saturate", 260, 1'b1, 1, 1'b0, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- hw/tr_top.sv
module tr_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           enable_req_i,
    // Operation in, only the inject bit of the tag is used
    input  tr_pkg::tr_req_t                op_i,
    input  logic                           valid_i,
    output logic                           ready_o,
    // Checked result out
    output logic [tr_pkg::DATA_W-1:0]      result_o,
    output logic                           faulty_o,
    output logic                           valid_o,
    input  logic                           ready_i,
    output logic [tr_pkg::FAULT_CNT_W-1:0] fault_count_o
);

    tr_pkg::tr_req_t req_in;
    tr_pkg::tr_req_t rep_req;
    tr_pkg::tr_req_t alu_req;
    tr_pkg::tr_rsp_t alu_rsp;
    tr_pkg::tr_rsp_t cmp_rsp;
    logic            rep_valid;
    logic            rep_ready;
    logic            alu_valid;
    logic            alu_ready;
    logic            cmp_valid;
    logic            cmp_ready;
    logic            enable;
    logic            hold;
    logic            accepted;
    logic            done;
    logic            fault;

    // Id and replica are stamped by the replicator
    assign req_in = '{
        op:  op_i.op,
        a:   op_i.a,
        b:   op_i.b,
        tag: '{id: '0, replica: 1'b0, inject: op_i.tag.inject}
    };

    tr_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .enable_req_i  (enable_req_i),
        .accepted_i    (accepted),
        .done_i        (done),
        .fault_i       (fault),
        .enable_o      (enable),
        .hold_o        (hold),
        .fault_count_o (fault_count_o)
    );

    tr_replicator u_replicator (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .enable_i   (enable),
        .hold_i     (hold),
        .req_i      (req_in),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .req_o      (rep_req),
        .valid_o    (rep_valid),
        .ready_i    (rep_ready),
        .accepted_o (accepted)
    );

    tr_pipe_stage #(.payload_t(tr_pkg::tr_req_t)) u_req_stage (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (rep_req),
        .valid_i (rep_valid),
        .ready_o (rep_ready),
        .data_o  (alu_req),
        .valid_o (alu_valid),
        .ready_i (alu_ready)
    );

    tr_alu u_alu (
        .req_i (alu_req),
        .rsp_o (alu_rsp)
    );

    tr_pipe_stage #(.payload_t(tr_pkg::tr_rsp_t)) u_rsp_stage (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (alu_rsp),
        .valid_i (alu_valid),
        .ready_o (alu_ready),
        .data_o  (cmp_rsp),
        .valid_o (cmp_valid),
        .ready_i (cmp_ready)
    );

    tr_comparator u_comparator (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .enable_i (enable),
        .rsp_i    (cmp_rsp),
        .valid_i  (cmp_valid),
        .ready_o  (cmp_ready),
        .result_o (result_o),
        .faulty_o (faulty_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .done_o   (done),
        .fault_o  (fault)
    );

endmodule

//--- hw/tr_ctrl.sv
module tr_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           enable_req_i,
    // Pulses from the replicator and comparator
    input  logic                           accepted_i,
    input  logic                           done_i,
    input  logic                           fault_i,
    output logic                           enable_o,
    output logic                           hold_o,
    output logic [tr_pkg::FAULT_CNT_W-1:0] fault_count_o
);

    logic [tr_pkg::INFLIGHT_W-1:0]  inflight_q;
    logic                           enable_q;
    logic [tr_pkg::FAULT_CNT_W-1:0] fault_cnt_q;

    // Mode change pending, stop new elements
    assign hold_o = enable_req_i != enable_q;

    // Elements between acceptance and completion
    always_ff @(posedge clk_i or negedge rst_ni) begin : inflight_ff
        if (!rst_ni) begin
            inflight_q <= '0;
        end else if (accepted_i && !done_i) begin
            inflight_q <= inflight_q + 1'b1;
        end else if (done_i && !accepted_i) begin
            inflight_q <= inflight_q - 1'b1;
        end
    end

    // Switch only on an empty pipeline
    always_ff @(posedge clk_i or negedge rst_ni) begin : enable_ff
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (hold_o && inflight_q == '0) begin
            enable_q <= enable_req_i;
        end
    end

    // Saturates at all ones
    always_ff @(posedge clk_i or negedge rst_ni) begin : fault_ff
        if (!rst_ni) begin
            fault_cnt_q <= '0;
        end else if (fault_i && fault_cnt_q != '1) begin
            fault_cnt_q <= fault_cnt_q + 1'b1;
        end
    end

    assign enable_o      = enable_q;
    assign fault_count_o = fault_cnt_q;

endmodule

//--- hw/tr_comparator.sv
`include "tr_vote.svh"

module tr_comparator (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      enable_i,
    // Upstream
    input  tr_pkg::tr_rsp_t           rsp_i,
    input  logic                      valid_i,
    output logic                      ready_o,
    // Downstream
    output logic [tr_pkg::DATA_W-1:0] result_o,
    output logic                      faulty_o,
    output logic                      valid_o,
    input  logic                      ready_i,
    // Status pulses for control
    output logic                      done_o,
    output logic                      fault_o
);

    // WAIT_FIRST: empty, next input is a first copy
    // WAIT_SECOND: first copy stored, output goes with the second copy
    // HOLD_OUT: both copies taken, downstream not ready yet
    typedef enum logic [1:0] {WAIT_FIRST, WAIT_SECOND, HOLD_OUT} state_e;

    state_e                    state_v [3];
    state_e                    state_d [3];
    state_e                    state_q [3];
    state_e                    state;
    logic [2:0]                fault_v;
    logic [2:0]                fault_d;
    logic [2:0]                fault_q;
    logic                      fault_cur;
    logic [tr_pkg::DATA_W-1:0] result_q;
    logic [tr_pkg::ID_W-1:0]   id_q;
    logic                      mismatch;

    // Second copy against the stored first copy
    assign mismatch = (rsp_i.result != result_q) || (rsp_i.tag.id != id_q);

    ////////////////////////////////////////////////////////////////////////////
    // Next state, three copies
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 0; r < 3; r++) begin : g_next
        always_comb begin
            state_v[r] = state_q[r];
            fault_v[r] = fault_q[r];
            case (state_q[r])
                WAIT_FIRST: begin
                    // Pass-through mode never leaves this state
                    if (enable_i && valid_i) begin
                        state_v[r] = WAIT_SECOND;
                    end
                end
                WAIT_SECOND: begin
                    if (valid_i) begin
                        // Keep the verdict for a stalled output
                        fault_v[r] = mismatch;
                        state_v[r] = ready_i ? WAIT_FIRST : HOLD_OUT;
                    end
                end
                HOLD_OUT: begin
                    if (ready_i) begin
                        state_v[r] = WAIT_FIRST;
                    end
                end
                default: state_v[r] = WAIT_FIRST;
            endcase
        end
    end

    always_comb begin : next_vote
        `TR_VOTE3TO3ENUM(state_v, state_d, state_e);
        `TR_VOTE3TO3(fault_v, fault_d);
    end

    always_comb begin : cur_vote
        `TR_VOTE3TO1ENUM(state_q, state, state_e);
        `TR_VOTE3TO1(fault_q, fault_cur);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q <= '{default: WAIT_FIRST};
            fault_q <= '0;
        end else begin
            state_q <= state_d;
            fault_q <= fault_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // First copy storage and outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin : first_ff
        if (enable_i && valid_i && state == WAIT_FIRST) begin
            result_q <= rsp_i.result;
            id_q     <= rsp_i.tag.id;
        end
    end

    always_comb begin : outputs
        result_o = result_q;
        faulty_o = 1'b0;
        valid_o  = 1'b0;
        ready_o  = 1'b1;
        if (!enable_i) begin
            // Single copies go straight through
            result_o = rsp_i.result;
            valid_o  = valid_i;
            ready_o  = ready_i;
        end else begin
            case (state)
                WAIT_SECOND: begin
                    valid_o  = valid_i;
                    faulty_o = valid_i & mismatch;
                end
                HOLD_OUT: begin
                    // No intake until the held result leaves
                    valid_o  = 1'b1;
                    faulty_o = fault_cur;
                    ready_o  = 1'b0;
                end
                default: begin
                    // First copy absorbed silently
                    ready_o = 1'b1;
                end
            endcase
        end
    end

    assign done_o  = valid_o & ready_i;
    assign fault_o = done_o & faulty_o;

endmodule

//--- hw/tr_replicator.sv
`include "tr_vote.svh"

module tr_replicator (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            enable_i,
    input  logic            hold_i,
    // Upstream
    input  tr_pkg::tr_req_t req_i,
    input  logic            valid_i,
    output logic            ready_o,
    // Downstream
    output tr_pkg::tr_req_t req_o,
    output logic            valid_o,
    input  logic            ready_i,
    output logic            accepted_o
);

    // STORE_AND_SEND: idle, first copy passes straight through
    // SEND: first copy stalled downstream, resend from the register
    // REPLICATE: second copy of the stored element
    typedef enum logic [1:0] {STORE_AND_SEND, SEND, REPLICATE} state_e;

    state_e                       state_v [3];
    state_e                       state_d [3];
    state_e                       state_q [3];
    state_e                       state;
    logic [2:0][tr_pkg::ID_W-1:0] id_v;
    logic [2:0][tr_pkg::ID_W-1:0] id_d;
    logic [2:0][tr_pkg::ID_W-1:0] id_q;
    logic [tr_pkg::ID_W-1:0]      id_cur;
    tr_pkg::tr_req_t              stamped;
    tr_pkg::tr_req_t              data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Next state, three copies
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 0; r < 3; r++) begin : g_next
        always_comb begin
            state_v[r] = state_q[r];
            id_v[r]    = id_q[r];
            case (state_q[r])
                STORE_AND_SEND: begin
                    if (valid_i && !hold_i) begin
                        // New element takes the current id
                        id_v[r] = id_q[r] + 1'b1;
                        if (!ready_i) begin
                            state_v[r] = SEND;
                        end else if (enable_i) begin
                            state_v[r] = REPLICATE;
                        end
                    end
                end
                SEND: begin
                    if (ready_i) begin
                        state_v[r] = enable_i ? REPLICATE : STORE_AND_SEND;
                    end
                end
                REPLICATE: begin
                    if (ready_i) begin
                        state_v[r] = STORE_AND_SEND;
                    end
                end
                default: state_v[r] = STORE_AND_SEND;
            endcase
        end
    end

    // Merge the copies before they are stored
    always_comb begin : next_vote
        `TR_VOTE3TO3ENUM(state_v, state_d, state_e);
        `TR_VOTE3TO3(id_v, id_d);
    end

    // Voted view of the stored copies for the outputs
    always_comb begin : cur_vote
        `TR_VOTE3TO1ENUM(state_q, state, state_e);
        `TR_VOTE3TO1(id_q, id_cur);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q <= '{default: STORE_AND_SEND};
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload and outputs
    ////////////////////////////////////////////////////////////////////////////

    // First copy with the id, inject only counts in redundant mode
    always_comb begin : stamp
        stamped             = req_i;
        stamped.tag.id      = id_cur;
        stamped.tag.replica = 1'b0;
        stamped.tag.inject  = req_i.tag.inject & enable_i;
    end

    // Element kept for a resend or the second copy
    always_ff @(posedge clk_i) begin : data_ff
        if (accepted_o) begin
            data_q <= stamped;
        end
    end

    always_comb begin : outputs
        req_o   = data_q;
        valid_o = 1'b1;
        ready_o = 1'b0;
        case (state)
            STORE_AND_SEND: begin
                // Control holds intake while a mode change is pending
                req_o   = stamped;
                valid_o = valid_i & ~hold_i;
                ready_o = ~hold_i;
            end
            REPLICATE: begin
                req_o.tag.replica = 1'b1;
            end
            default: begin
                req_o = data_q;
            end
        endcase
    end

    assign accepted_o = valid_i & ready_o;

endmodule

//--- hw/tr_alu.sv
module tr_alu (
    input  tr_pkg::tr_req_t req_i,
    output tr_pkg::tr_rsp_t rsp_o
);

    logic [tr_pkg::DATA_W-1:0] result;
    logic [tr_pkg::DATA_W-1:0] product;
    logic                      flip;

    // Truncated to the low half by the target width
    assign product = req_i.a * req_i.b;

    always_comb begin : compute
        case (req_i.op)
            tr_pkg::ALU_ADD: result = req_i.a + req_i.b;
            tr_pkg::ALU_SUB: result = req_i.a - req_i.b;
            tr_pkg::ALU_XOR: result = req_i.a ^ req_i.b;
            tr_pkg::ALU_MUL: result = product;
            default:         result = '0;
        endcase
    end

    // Corrupt the second copy only, first copy stays the reference
    assign flip = req_i.tag.replica & req_i.tag.inject;

    assign rsp_o.result = flip ? (result ^ tr_pkg::INJECT_MASK) : result;
    // Tag rides along untouched
    assign rsp_o.tag    = req_i.tag;

endmodule

//--- hw/tr_pipe_stage.sv
module tr_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    // Upstream
    input  payload_t data_i,
    input  logic     valid_i,
    output logic     ready_o,
    // Downstream
    output payload_t data_o,
    output logic     valid_o,
    input  logic     ready_i
);

    logic     valid_q;
    payload_t data_q;

    // Free when empty or draining this cycle, so full throughput
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_ff
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload only moves on an input transfer
    always_ff @(posedge clk_i) begin : data_ff
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

//--- hw/tr_pkg.sv
package tr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Operand and result width
    localparam int unsigned DATA_W      = 16;
    // Tag id width, wraps in order
    localparam int unsigned ID_W        = 2;
    // Saturating fault counter width
    localparam int unsigned FAULT_CNT_W = 8;
    // Elements between acceptance and completion, a handful at most
    localparam int unsigned INFLIGHT_W  = 3;

    // Bits flipped in a second copy when injection is requested
    localparam logic [DATA_W-1:0] INJECT_MASK = 16'h8001;

    ////////////////////////////////////////////////////////////////////////////
    // Operation codes and payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2,
        ALU_MUL = 2'd3   // Low half of the product
    } alu_op_e;

    // Tag that travels with each copy
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            replica;  // 0 first copy, 1 second copy
        logic            inject;   // Error-inject request
    } tr_tag_t;

    typedef struct packed {
        alu_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        tr_tag_t           tag;
    } tr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        tr_tag_t           tag;
    } tr_rsp_t;

endpackage

//--- hw/tr_vote.svh
`ifndef TR_VOTE_SVH
`define TR_VOTE_SVH

// Bitwise two-out-of-three majority
`define TR_MAJ(a, b, c) (((a) & (b)) | ((a) & (c)) | ((b) & (c)))

// Three copies down to one value, for bits and packed vectors
`define TR_VOTE3TO1(in_sig, out_sig) \
    out_sig = `TR_MAJ(in_sig[0], in_sig[1], in_sig[2])

// Three copies voted back into three copies
`define TR_VOTE3TO3(in_sig, out_sig) \
    begin \
        out_sig[0] = `TR_MAJ(in_sig[0], in_sig[1], in_sig[2]); \
        out_sig[1] = `TR_MAJ(in_sig[0], in_sig[1], in_sig[2]); \
        out_sig[2] = `TR_MAJ(in_sig[0], in_sig[1], in_sig[2]); \
    end

// Enum arrays, result cast back to the state type
`define TR_VOTE3TO1ENUM(in_sig, out_sig, enum_t) \
    out_sig = enum_t'(`TR_MAJ(in_sig[0], in_sig[1], in_sig[2]))

`define TR_VOTE3TO3ENUM(in_sig, out_sig, enum_t) \
    begin \
        out_sig[0] = enum_t'(`TR_MAJ(in_sig[0], in_sig[1], in_sig[2])); \
        out_sig[1] = enum_t'(`TR_MAJ(in_sig[0], in_sig[1], in_sig[2])); \
        out_sig[2] = enum_t'(`TR_MAJ(in_sig[0], in_sig[1], in_sig[2])); \
    end

`endif
